// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN = 32;
    localparam int REG_W = 5;
    localparam int SHAMT_W = $clog2(XLEN);

    // Divider iterations, one quotient bit each.
    localparam int DIV_STEPS = 32;

    localparam int DEFAULT_LANES = 2;

    typedef logic [XLEN-1:0] word_t;

    // Bit 4 clear is ALU, 2'b10 on bits 4:3 is multiply, 2'b11 is divide.
    typedef enum logic [4:0] {
        OP_ADD   = 5'b00000,
        OP_SUB   = 5'b00001,
        OP_SLT   = 5'b00010,
        OP_SLTU  = 5'b00011,
        OP_SEQ   = 5'b00100,
        OP_AND   = 5'b00101,
        OP_OR    = 5'b00110,
        OP_XOR   = 5'b00111,
        OP_SLL   = 5'b01000,
        OP_SRL   = 5'b01001,
        OP_SRA   = 5'b01010,
        OP_MUL   = 5'b10000,
        OP_MULH  = 5'b10001,
        OP_MULHU = 5'b10010,
        OP_DIV   = 5'b11000,
        OP_DIVU  = 5'b11001,
        OP_MOD   = 5'b11010,
        OP_MODU  = 5'b11011
    } op_t;

endpackage

// ==== verilog/ex_slot_if.sv ====
`timescale 1ns/1ps

interface ex_slot_if import ex_pkg::*; ();

    // Issued operation.
    logic             valid;
    logic             start;
    word_t            pc;
    op_t              op;
    word_t            src1;
    word_t            src2;
    logic [REG_W-1:0] dest;
    logic             is_branch;
    logic             branch_cond;
    logic             is_jirl;
    word_t            branch_target;
    logic             pred_taken;
    word_t            pred_target;

    // Lane outcome.
    logic             ready;
    word_t            result;
    logic             taken;
    word_t            target;
    logic             mispredict;

    modport issue (
        output valid, start, pc, op, src1, src2, dest, is_branch, branch_cond,
               is_jirl, branch_target, pred_taken, pred_target
    );

    modport lane (
        input  valid, start, pc, op, src1, src2, is_branch, branch_cond,
               is_jirl, branch_target, pred_taken, pred_target,
        output ready, result, taken, target, mispredict
    );

    modport retire (
        input valid, pc, dest, ready, result, taken, target, mispredict
    );

endinterface

// ==== verilog/ex_divider.sv ====
`timescale 1ns/1ps

module ex_divider import ex_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  abort,
    input  logic  start,
    input  word_t dividend,
    input  word_t divisor,
    output logic  done,
    output word_t quotient,
    output word_t remainder
);

    localparam int CNT_W = $clog2(DIV_STEPS + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    word_t            dsr;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;

    // Bring in the next dividend bit and try the subtraction.
    assign shifted = {remainder, quotient[XLEN-1]};
    assign diff    = shifted - {1'b0, dsr};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (abort) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (start) begin
            busy  <= 1'b1;
            done  <= 1'b0;
            count <= CNT_W'(DIV_STEPS);
        end else if (busy) begin
            count <= count - 1'b1;
            if (count == CNT_W'(1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else begin
            done <= 1'b0;
        end
    end

    // Zero divisor falls out as all ones and the dividend.
    always_ff @(posedge clk) begin
        if (start) begin
            dsr       <= divisor;
            quotient  <= dividend;
            remainder <= '0;
        end else if (busy) begin
            if (!diff[XLEN]) begin
                remainder <= diff[XLEN-1:0];
                quotient  <= {quotient[XLEN-2:0], 1'b1};
            end else begin
                remainder <= shifted[XLEN-1:0];
                quotient  <= {quotient[XLEN-2:0], 1'b0};
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
        (start && !abort) |-> !busy);

endmodule

// ==== verilog/ex_lane.sv ====
`timescale 1ns/1ps

module ex_lane import ex_pkg::*; (
    input logic     clk,
    input logic     arst_n,
    input logic     flush,
    ex_slot_if.lane slot
);

    logic              is_alu;
    logic              is_mul;
    logic              is_div;
    logic              mul_sign_ex;
    logic              div_signed;
    logic [XLEN:0]     mul_a;
    logic [XLEN:0]     mul_b;
    logic [2*XLEN-1:0] product;
    logic              mul_done;
    logic              div_pending;
    logic              div_start;
    logic              div_done;
    word_t             div_dividend;
    word_t             div_divisor;
    word_t             quotient;
    word_t             remainder;
    word_t             quo_res;
    word_t             rem_res;
    word_t             sum;
    word_t             alu_result;
    word_t             op_result;

    assign is_alu = !slot.op[4];
    assign is_mul = slot.op[4:3] == 2'b10;
    assign is_div = slot.op[4:3] == 2'b11;

    assign sum = slot.src1 + slot.src2;

    always_comb begin
        case (slot.op)
            OP_ADD:  alu_result = sum;
            OP_SUB:  alu_result = slot.src1 - slot.src2;
            OP_SLT:  alu_result = word_t'($signed(slot.src1) < $signed(slot.src2));
            OP_SLTU: alu_result = word_t'(slot.src1 < slot.src2);
            OP_SEQ:  alu_result = word_t'(slot.src1 == slot.src2);
            OP_AND:  alu_result = slot.src1 & slot.src2;
            OP_OR:   alu_result = slot.src1 | slot.src2;
            OP_XOR:  alu_result = slot.src1 ^ slot.src2;
            OP_SLL:  alu_result = slot.src1 << slot.src2[SHAMT_W-1:0];
            OP_SRL:  alu_result = slot.src1 >> slot.src2[SHAMT_W-1:0];
            OP_SRA:  alu_result = word_t'($signed(slot.src1) >>> slot.src2[SHAMT_W-1:0]);
            default: alu_result = '0;
        endcase
    end

    // Only MULH sees signed operands.
    assign mul_sign_ex = slot.op == OP_MULH;
    assign mul_a = {mul_sign_ex && slot.src1[XLEN-1], slot.src1};
    assign mul_b = {mul_sign_ex && slot.src2[XLEN-1], slot.src2};

    always_ff @(posedge clk) begin
        if (slot.start && is_mul) begin
            product <= (2 * XLEN)'($signed(mul_a) * $signed(mul_b));
        end
    end

    // Divide on magnitudes, then fix signs.
    assign div_signed   = slot.op == OP_DIV || slot.op == OP_MOD;
    assign div_dividend = (div_signed && slot.src1[XLEN-1]) ? -slot.src1 : slot.src1;
    assign div_divisor  = (div_signed && slot.src2[XLEN-1]) ? -slot.src2 : slot.src2;
    assign div_start    = slot.start && is_div;

    ex_divider divider_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .abort     (flush),
        .start     (div_start),
        .dividend  (div_dividend),
        .divisor   (div_divisor),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign quo_res = (div_signed && (slot.src1[XLEN-1] ^ slot.src2[XLEN-1])) ? -quotient
                                                                             : quotient;
    assign rem_res = (div_signed && slot.src1[XLEN-1]) ? -remainder : remainder;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mul_done    <= 1'b0;
            div_pending <= 1'b0;
        end else if (flush) begin
            mul_done    <= 1'b0;
            div_pending <= 1'b0;
        end else begin
            if (slot.start) begin
                mul_done <= is_mul;
            end
            if (div_start) begin
                div_pending <= 1'b1;
            end else if (div_done) begin
                div_pending <= 1'b0;
            end
        end
    end

    // Start marks a fresh op, so stale unit state is ignored then.
    assign slot.ready = slot.valid && (is_alu
                                       || (is_mul && mul_done && !slot.start)
                                       || (is_div && (div_done || !div_pending)
                                           && !slot.start));

    always_comb begin
        case (slot.op)
            OP_MUL:            op_result = product[XLEN-1:0];
            OP_MULH, OP_MULHU: op_result = product[2*XLEN-1:XLEN];
            OP_DIV, OP_DIVU:   op_result = quo_res;
            OP_MOD, OP_MODU:   op_result = rem_res;
            default:           op_result = alu_result;
        endcase
    end

    // Link value for jirl.
    assign slot.result = slot.is_jirl ? slot.pc + word_t'(4) : op_result;

    assign slot.taken  = slot.is_jirl || (slot.is_branch && slot.branch_cond == alu_result[0]);
    assign slot.target = slot.is_jirl ? sum : slot.branch_target;
    assign slot.mispredict = slot.taken != slot.pred_taken
                             || (slot.taken && slot.target != slot.pred_target);

endmodule

// ==== verilog/ex_issue.sv ====
`timescale 1ns/1ps

module ex_issue import ex_pkg::*; #(
    parameter int NUM_LANES = DEFAULT_LANES
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             in_pair_ready,
    input  logic             stall,
    input  logic             in_valid         [NUM_LANES],
    input  word_t            in_pc            [NUM_LANES],
    input  op_t              in_op            [NUM_LANES],
    input  word_t            in_src1          [NUM_LANES],
    input  word_t            in_src2          [NUM_LANES],
    input  logic [REG_W-1:0] in_dest          [NUM_LANES],
    input  logic             in_is_branch     [NUM_LANES],
    input  logic             in_branch_cond   [NUM_LANES],
    input  logic             in_is_jirl       [NUM_LANES],
    input  word_t            in_branch_target [NUM_LANES],
    input  logic             in_pred_taken    [NUM_LANES],
    input  word_t            in_pred_target   [NUM_LANES],
    ex_slot_if.issue         slot             [NUM_LANES]
);

    logic                 accept;
    logic [NUM_LANES-1:0] occupied;

    // A new pair enters only when the stage is free to move.
    assign accept = in_pair_ready && !stall;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        logic load;

        assign load        = accept && in_valid[i];
        assign occupied[i] = slot[i].valid;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                slot[i].valid <= 1'b0;
                slot[i].start <= 1'b0;
            end else if (flush) begin
                slot[i].valid <= 1'b0;
                slot[i].start <= 1'b0;
            end else begin
                if (!stall) begin
                    slot[i].valid <= load;
                end
                slot[i].start <= load;
            end
        end

        always_ff @(posedge clk) begin
            if (load) begin
                slot[i].pc            <= in_pc[i];
                slot[i].op            <= in_op[i];
                slot[i].src1          <= in_src1[i];
                slot[i].src2          <= in_src2[i];
                slot[i].dest          <= in_dest[i];
                slot[i].is_branch     <= in_is_branch[i];
                slot[i].branch_cond   <= in_branch_cond[i];
                slot[i].is_jirl       <= in_is_jirl[i];
                slot[i].branch_target <= in_branch_target[i];
                slot[i].pred_taken    <= in_pred_taken[i];
                slot[i].pred_target   <= in_pred_target[i];
            end
        end
    end

    // Stall only ever holds a pair that is really there.
    a_stall_held: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> |occupied);

endmodule

// ==== verilog/ex_retire.sv ====
`timescale 1ns/1ps

module ex_retire import ex_pkg::*; #(
    parameter int NUM_LANES = DEFAULT_LANES
) (
    input  logic             allowout,
    ex_slot_if.retire        slot          [NUM_LANES],
    output logic             ex_valid      [NUM_LANES],
    output word_t            ex_result     [NUM_LANES],
    output logic [REG_W-1:0] ex_dest       [NUM_LANES],
    output word_t            ex_pc         [NUM_LANES],
    output logic             ex_taken      [NUM_LANES],
    output word_t            ex_target     [NUM_LANES],
    output logic             ex_mispredict [NUM_LANES],
    output logic             ex_both_ready,
    output logic             ex_stall
);

    logic [NUM_LANES-1:0] lane_valid;
    logic [NUM_LANES-1:0] lane_done;
    logic                 any_valid;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        // Empty lanes never hold the pair back.
        assign lane_valid[i] = slot[i].valid;
        assign lane_done[i]  = !slot[i].valid || slot[i].ready;

        assign ex_valid[i]  = slot[i].valid;
        assign ex_result[i] = slot[i].result;
        assign ex_dest[i]   = slot[i].dest;
        assign ex_pc[i]     = slot[i].pc;
        assign ex_taken[i]  = slot[i].taken;
        assign ex_target[i] = slot[i].target;

        // Redirect only once, on the handoff cycle.
        assign ex_mispredict[i] = slot[i].valid && !ex_stall && slot[i].mispredict;
    end

    assign any_valid     = |lane_valid;
    assign ex_both_ready = any_valid && (&lane_done);
    assign ex_stall      = any_valid && (!ex_both_ready || !allowout);

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage import ex_pkg::*; #(
    parameter int NUM_LANES = DEFAULT_LANES
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             flush,
    input  logic             allowout,
    input  logic             in_pair_ready,
    input  logic             in_valid         [NUM_LANES],
    input  word_t            in_pc            [NUM_LANES],
    input  op_t              in_op            [NUM_LANES],
    input  word_t            in_src1          [NUM_LANES],
    input  word_t            in_src2          [NUM_LANES],
    input  logic [REG_W-1:0] in_dest          [NUM_LANES],
    input  logic             in_is_branch     [NUM_LANES],
    input  logic             in_branch_cond   [NUM_LANES],
    input  logic             in_is_jirl       [NUM_LANES],
    input  word_t            in_branch_target [NUM_LANES],
    input  logic             in_pred_taken    [NUM_LANES],
    input  word_t            in_pred_target   [NUM_LANES],
    output logic             ex_valid         [NUM_LANES],
    output word_t            ex_result        [NUM_LANES],
    output logic [REG_W-1:0] ex_dest          [NUM_LANES],
    output word_t            ex_pc            [NUM_LANES],
    output logic             ex_taken         [NUM_LANES],
    output word_t            ex_target        [NUM_LANES],
    output logic             ex_mispredict    [NUM_LANES],
    output logic             ex_both_ready,
    output logic             ex_stall
);

    ex_slot_if slot [NUM_LANES] ();

    ex_issue #(
        .NUM_LANES (NUM_LANES)
    ) issue_i (
        .clk              (clk),
        .arst_n           (arst_n),
        .flush            (flush),
        .in_pair_ready    (in_pair_ready),
        .stall            (ex_stall),
        .in_valid         (in_valid),
        .in_pc            (in_pc),
        .in_op            (in_op),
        .in_src1          (in_src1),
        .in_src2          (in_src2),
        .in_dest          (in_dest),
        .in_is_branch     (in_is_branch),
        .in_branch_cond   (in_branch_cond),
        .in_is_jirl       (in_is_jirl),
        .in_branch_target (in_branch_target),
        .in_pred_taken    (in_pred_taken),
        .in_pred_target   (in_pred_target),
        .slot             (slot)
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        ex_lane lane_i (
            .clk    (clk),
            .arst_n (arst_n),
            .flush  (flush),
            .slot   (slot[i])
        );
    end

    ex_retire #(
        .NUM_LANES (NUM_LANES)
    ) retire_i (
        .allowout      (allowout),
        .slot          (slot),
        .ex_valid      (ex_valid),
        .ex_result     (ex_result),
        .ex_dest       (ex_dest),
        .ex_pc         (ex_pc),
        .ex_taken      (ex_taken),
        .ex_target     (ex_target),
        .ex_mispredict (ex_mispredict),
        .ex_both_ready (ex_both_ready),
        .ex_stall      (ex_stall)
    );

endmodule

// ==== bench/ex_model.svh ====
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

// Reference behavior of one execution lane.

function automatic word_t model_alu(op_t op, word_t a, word_t b);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
        OP_SEQ:  return (a == b) ? 32'd1 : 32'd0;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        OP_SLL:  return a << b[4:0];
        OP_SRL:  return a >> b[4:0];
        OP_SRA:  return $signed(a) >>> b[4:0];
        default: return '0;
    endcase
endfunction

function automatic word_t model_mul(op_t op, word_t a, word_t b);
    longint      sp;
    logic [63:0] up;
    sp = longint'($signed(a)) * longint'($signed(b));
    up = {32'd0, a} * {32'd0, b};
    case (op)
        OP_MULH:  return sp[63:32];
        OP_MULHU: return up[63:32];
        default:  return up[31:0];
    endcase
endfunction

function automatic word_t model_div(op_t op, word_t a, word_t b);
    longint sa;
    longint sb;
    word_t  q;
    word_t  r;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    if (b == 0) begin
        // All-ones magnitude, negated for a negative signed dividend.
        q = (a[31] && (op == OP_DIV || op == OP_MOD)) ? 32'd1 : '1;
        r = a;
    end else if (op == OP_DIVU || op == OP_MODU) begin
        q = a / b;
        r = a % b;
    end else begin
        // Longint division truncates toward zero.
        q = word_t'(sa / sb);
        r = word_t'(sa % sb);
    end
    return (op == OP_DIV || op == OP_DIVU) ? q : r;
endfunction

function automatic word_t model_result(op_t op, word_t a, word_t b, word_t pc, logic is_jirl);
    if (is_jirl) begin
        return pc + 32'd4;
    end
    case (op[4:3])
        2'b10:   return model_mul(op, a, b);
        2'b11:   return model_div(op, a, b);
        default: return model_alu(op, a, b);
    endcase
endfunction

function automatic logic model_taken(op_t op, word_t a, word_t b, logic is_branch,
                                     logic cond, logic is_jirl);
    word_t v;
    v = model_alu(op, a, b);
    return is_jirl || (is_branch && v[0] == cond);
endfunction

function automatic word_t model_target(logic is_jirl, word_t a, word_t b, word_t bt);
    return is_jirl ? a + b : bt;
endfunction

function automatic logic model_mispredict(logic taken, word_t target, logic pred_taken,
                                          word_t pred_target);
    return taken != pred_taken || (taken && target != pred_target);
endfunction

`endif

// ==== bench/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb import ex_pkg::*; ();

    localparam int NUM_LANES = 2;
    localparam int PERIOD = 8;
    localparam int PAIRS_PER_TEST = 60;
    localparam int NUM_TESTS = 5;
    localparam int NUM_OPS = PAIRS_PER_TEST * NUM_TESTS * NUM_LANES;
    localparam int TIMEOUT = NUM_OPS * (DIV_STEPS + 4) * PERIOD;

    typedef struct packed {
        logic             valid;
        word_t            pc;
        op_t              op;
        word_t            src1;
        word_t            src2;
        logic [REG_W-1:0] dest;
        logic             is_branch;
        logic             branch_cond;
        logic             is_jirl;
        word_t            branch_target;
        logic             pred_taken;
        word_t            pred_target;
    } op_rec_t;

    typedef op_rec_t [NUM_LANES-1:0] pair_t;

    `include "ex_model.svh"

    logic             clk;
    logic             arst_n;
    logic             flush;
    logic             allowout;
    logic             in_pair_ready;
    logic             in_valid         [NUM_LANES];
    word_t            in_pc            [NUM_LANES];
    op_t              in_op            [NUM_LANES];
    word_t            in_src1          [NUM_LANES];
    word_t            in_src2          [NUM_LANES];
    logic [REG_W-1:0] in_dest          [NUM_LANES];
    logic             in_is_branch     [NUM_LANES];
    logic             in_branch_cond   [NUM_LANES];
    logic             in_is_jirl       [NUM_LANES];
    word_t            in_branch_target [NUM_LANES];
    logic             in_pred_taken    [NUM_LANES];
    word_t            in_pred_target   [NUM_LANES];
    logic             ex_valid         [NUM_LANES];
    word_t            ex_result        [NUM_LANES];
    logic [REG_W-1:0] ex_dest          [NUM_LANES];
    word_t            ex_pc            [NUM_LANES];
    logic             ex_taken         [NUM_LANES];
    word_t            ex_target        [NUM_LANES];
    logic             ex_mispredict    [NUM_LANES];
    logic             ex_both_ready;
    logic             ex_stall;

    // Accepted pairs in hand-off order.
    pair_t pair_q[$];
    int    checks;
    int    errors;
    int    handed;
    int    flushed;
    int    seq;
    int    age;
    int    gen_kind;
    bit    draining;
    bit    flush_on;
    logic  held;
    word_t snap_result [NUM_LANES];
    word_t snap_target [NUM_LANES];
    logic  snap_taken  [NUM_LANES];

    ex_stage #(
        .NUM_LANES (NUM_LANES)
    ) dut_i (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    initial begin
        #(TIMEOUT);
        $display("Timeout after %0d ns with the stage no longer handing off pairs", TIMEOUT);
        $display("Some tests failed");
        $finish;
    end

    task automatic check_word(input int lane, input string what, input word_t got,
                              input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: lane %0d %s got %h expected %h", $time, lane, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic op_t pick_op(int cls);
        int unsigned r;
        r = $urandom;
        case (cls)
            1:       return op_t'(5'b10000 + 5'(r % 3));
            2:       return op_t'(5'b11000 + 5'(r % 4));
            default: return op_t'(5'(r % 11));
        endcase
    endfunction

    // Corner values show up often enough to hit zero divisors and overflow.
    function automatic word_t pick_operand();
        case ($urandom % 8)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;
            3:       return word_t'($urandom % 16);
            default: return $urandom;
        endcase
    endfunction

    // Cycles after the latching edge until a lane may hand off.
    function automatic int op_latency(op_t op);
        case (op[4:3])
            2'b10:   return 1;
            2'b11:   return DIV_STEPS + 1;
            default: return 0;
        endcase
    endfunction

    task automatic drive_inputs();
        op_t         op;
        word_t       a;
        word_t       b;
        word_t       bt;
        logic        ctl;
        int unsigned r;
        int          cls;
        in_pair_ready <= ($urandom % 4) != 0;
        allowout      <= ($urandom % 3) != 0;
        flush         <= flush_on && (($urandom % 40) == 0);
        for (int i = 0; i < NUM_LANES; i++) begin
            cls = (gen_kind == 4) ? int'($urandom % 3) : ((gen_kind == 3) ? 0 : gen_kind);
            op  = pick_op(cls);
            a   = pick_operand();
            b   = pick_operand();
            bt  = $urandom & ~32'h3;
            r   = $urandom % 4;
            ctl = (gen_kind == 3) || (gen_kind == 4 && !op[4] && r < 2);
            in_valid[i]         <= !draining && (($urandom % 8) != 0);
            in_pc[i]            <= 32'h1c00_0000 + word_t'(seq << 2);
            in_op[i]            <= op;
            in_src1[i]          <= a;
            in_src2[i]          <= b;
            in_dest[i]          <= REG_W'($urandom);
            in_is_branch[i]     <= ctl && r != 0;
            in_branch_cond[i]   <= 1'($urandom);
            in_is_jirl[i]       <= ctl && r == 0;
            in_branch_target[i] <= bt;
            in_pred_taken[i]    <= ctl ? 1'($urandom) : 1'b0;
            in_pred_target[i]   <= (($urandom % 2) == 0) ? model_target(ctl && r == 0, a, b, bt)
                                                         : ($urandom & ~32'h3);
            seq++;
        end
    endtask

    task automatic compare_pair(input pair_t p);
        op_rec_t r;
        logic    tk;
        word_t   tg;
        for (int i = 0; i < NUM_LANES; i++) begin
            r = p[i];
            if (r.valid) begin
                tk = model_taken(r.op, r.src1, r.src2, r.is_branch, r.branch_cond, r.is_jirl);
                tg = model_target(r.is_jirl, r.src1, r.src2, r.branch_target);
                check_word(i, "pc", ex_pc[i], r.pc);
                check_word(i, "dest", word_t'(ex_dest[i]), word_t'(r.dest));
                check_word(i, "result", ex_result[i],
                           model_result(r.op, r.src1, r.src2, r.pc, r.is_jirl));
                check_word(i, "taken", word_t'(ex_taken[i]), word_t'(tk));
                check_word(i, "target", ex_target[i], tg);
                check_word(i, "mispredict", word_t'(ex_mispredict[i]),
                           word_t'(model_mispredict(tk, tg, r.pred_taken, r.pred_target)));
            end
        end
    endtask

    // Runs between edges, so outputs and inputs are settled.
    task automatic check_cycle();
        pair_t front;
        pair_t incoming;
        logic  handoff;
        logic  any_in;
        logic  exp_ready;
        logic  exp_stall;
        handoff   = 1'b0;
        any_in    = 1'b0;
        exp_ready = 1'b0;
        exp_stall = 1'b0;
        if (held) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                check_word(i, "held result", ex_result[i], snap_result[i]);
                check_word(i, "held target", ex_target[i], snap_target[i]);
                check_word(i, "held taken", word_t'(ex_taken[i]), word_t'(snap_taken[i]));
            end
        end
        if (pair_q.size() == 0) begin
            check_flag("idle stall", ex_stall, 1'b0);
            check_flag("idle both_ready", ex_both_ready, 1'b0);
            for (int i = 0; i < NUM_LANES; i++) begin
                check_flag("idle valid", ex_valid[i], 1'b0);
            end
        end else begin
            front     = pair_q[0];
            exp_ready = 1'b1;
            for (int i = 0; i < NUM_LANES; i++) begin
                if (front[i].valid && age < op_latency(front[i].op)) begin
                    exp_ready = 1'b0;
                end
            end
            exp_stall = !(exp_ready && allowout);
            for (int i = 0; i < NUM_LANES; i++) begin
                check_flag("valid", ex_valid[i], front[i].valid);
                if (exp_stall) begin
                    check_flag("mispredict while stalled", ex_mispredict[i], 1'b0);
                end
            end
            check_flag("both_ready", ex_both_ready, exp_ready);
            check_flag("stall", ex_stall, exp_stall);
            if (!exp_stall && !flush) begin
                compare_pair(front);
                void'(pair_q.pop_front());
                handed++;
                handoff = 1'b1;
            end else begin
                age++;
            end
        end
        held = !handoff && !flush && exp_ready && !allowout;
        for (int i = 0; i < NUM_LANES; i++) begin
            snap_result[i] = ex_result[i];
            snap_target[i] = ex_target[i];
            snap_taken[i]  = ex_taken[i];
        end
        if (flush) begin
            flushed += pair_q.size();
            pair_q.delete();
        end else if (in_pair_ready && !exp_stall) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                incoming[i] = '{in_valid[i], in_pc[i], in_op[i], in_src1[i], in_src2[i],
                                in_dest[i], in_is_branch[i], in_branch_cond[i],
                                in_is_jirl[i], in_branch_target[i], in_pred_taken[i],
                                in_pred_target[i]};
                any_in |= in_valid[i];
            end
            if (any_in) begin
                pair_q.push_back(incoming);
                age = 0;
            end
        end
    endtask

    task automatic step();
        @(negedge clk);
        check_cycle();
        @(posedge clk);
        drive_inputs();
    endtask

    task automatic run_test(input string name, input int kind, input bit with_flush);
        int chk0;
        int err0;
        int target;
        chk0     = checks;
        err0     = errors;
        target   = handed + PAIRS_PER_TEST;
        gen_kind = kind;
        flush_on = with_flush;
        draining = 1'b0;
        while (handed < target) begin
            step();
        end
        draining = 1'b1;
        while (pair_q.size() != 0) begin
            step();
        end
        draining = 1'b0;
        $display("test %s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial begin
        void'($urandom(32'hb5c9));
        checks  = 0;
        errors  = 0;
        handed  = 0;
        flushed = 0;
        seq     = 0;
        age     = 0;
        held    = 1'b0;
        arst_n        <= 1'b0;
        flush         <= 1'b0;
        allowout      <= 1'b0;
        in_pair_ready <= 1'b0;
        for (int i = 0; i < NUM_LANES; i++) begin
            in_valid[i]         <= 1'b0;
            in_pc[i]            <= '0;
            in_op[i]            <= OP_ADD;
            in_src1[i]          <= '0;
            in_src2[i]          <= '0;
            in_dest[i]          <= '0;
            in_is_branch[i]     <= 1'b0;
            in_branch_cond[i]   <= 1'b0;
            in_is_jirl[i]       <= 1'b0;
            in_branch_target[i] <= '0;
            in_pred_taken[i]    <= 1'b0;
            in_pred_target[i]   <= '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        run_test("alu", 0, 1'b0);
        run_test("mul", 1, 1'b0);
        run_test("div", 2, 1'b0);
        run_test("branch", 3, 1'b0);
        run_test("mixed_flush", 4, 1'b1);
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d pairs retired, %0d flushed",
                 NUM_TESTS, checks, errors, handed, flushed);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+bench
verilog/ex_pkg.sv
verilog/ex_slot_if.sv
verilog/ex_divider.sv
verilog/ex_lane.sv
verilog/ex_issue.sv
verilog/ex_retire.sv
verilog/ex_stage.sv
bench/ex_stage_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = ex_stage_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
PASS_MSG  = All tests passed

.PHONY: compile run clean

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
